// File: hdl/sbaskt_consts.svh
// Super Basketball ROM map
// Region starts in SDRAM and the address widths of the ROM reader slots

`ifndef SBASKT_CONSTS_SVH
`define SBASKT_CONSTS_SVH

// Byte offsets of each region in SDRAM, main CPU code sits at zero
`define SND_START   22'h01_0000
`define SCR_START   22'h01_2000
`define OBJ_START   22'h01_A000
`define PCM_START   22'h02_A000

// PROMs follow the PCM samples in the download
`define PROM_START  25'h003_A000

// Slot address widths
`define MAIN_AW     16
`define SND_AW      13
`define SCR_AW      13
`define OBJ_AW      14

`endif

// File: hdl/sbaskt_pkg.sv
// Shared types of the ROM subsystem
// Programming bus, slot read requests and burst completions

package sbaskt_pkg;

    typedef logic [ 7:0] byte_data_t;
    typedef logic [31:0] word_data_t;

    // Download write towards the SDRAM and the PROMs
    typedef struct packed {
        logic [21:0] addr;
        logic [ 7:0] data;
        logic [ 1:0] mask;      // active low
        logic        we;
        logic        prom_we;
    } prog_bus_t;

    // Read request from one slot, addr is an SDRAM word address
    typedef struct packed {
        logic        req;
        logic [21:0] addr;
    } rd_req_t;

    // Two-word burst, the first word in the low half
    typedef struct packed {
        logic        done;
        logic [31:0] data;
    } rd_rsp_t;

endpackage

// File: hdl/sbaskt_dwnld.sv
// ROM download decoder
// Converts the ioctl byte stream into programming bus writes and PROM strobes

`include "sbaskt_consts.svh"

module sbaskt_dwnld import sbaskt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [24:0] ioctl_addr,
    input  logic [ 7:0] ioctl_dout,
    input  logic        ioctl_wr,
    output prog_bus_t   prog
);

    localparam logic [24:0] GFX_LO  = {3'd0, `SCR_START};
    localparam logic [24:0] GFX_HI  = {3'd0, `PCM_START};
    localparam logic [24:0] PROM_LO = `PROM_START;

    logic        is_prom;
    logic        is_gfx;
    logic [ 7:0] byte_in;
    logic        we_q;
    logic        prom_we_q;
    logic [21:0] addr_q;
    logic [ 7:0] data_q;
    logic [ 1:0] mask_q;

    assign is_prom = ioctl_addr >= PROM_LO;
    assign is_gfx  = ioctl_addr >= GFX_LO && ioctl_addr < GFX_HI;

    // Tile and object graphics are stored with nibbles swapped
    assign byte_in = is_gfx ? {ioctl_dout[3:0], ioctl_dout[7:4]} : ioctl_dout;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            we_q      <= 1'b0;
            prom_we_q <= 1'b0;
        end else begin
            we_q      <= ioctl_wr && !is_prom;
            prom_we_q <= ioctl_wr && is_prom;
        end
    end

    // Even bytes go to the low lane
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            addr_q <= ioctl_addr[22:1];
            data_q <= byte_in;
            mask_q <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end
    end

    assign prog = '{
        addr:    addr_q,
        data:    data_q,
        mask:    mask_q,
        we:      we_q,
        prom_we: prom_we_q
    };

endmodule

// File: hdl/sbaskt_rom_slot.sv
// ROM reader slot
// One-entry cache in front of the SDRAM, requests a burst on a miss

module sbaskt_rom_slot import sbaskt_pkg::*; #(
    parameter type         data_t = byte_data_t,
    parameter int unsigned AW     = 16,
    parameter logic [21:0] OFFSET = 22'd0
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          downloading,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output data_t         data,
    output logic          ok,
    output rd_req_t       rd,
    input  rd_rsp_t       rsp
);

    localparam bit          BYTE_SLOT = $bits(data_t) == 8;
    localparam logic [21:0] BASE      = {1'b0, OFFSET[21:1]};

    logic          valid;
    logic [AW-1:0] tag;
    data_t         cache;
    logic          pend;
    logic [AW-1:0] pend_addr;
    logic [21:0]   word_addr;
    data_t         fill_data;
    logic          hit;
    logic          miss;

    assign hit  = valid && !downloading && tag == addr;
    assign miss = cs && !hit && !downloading;
    assign ok   = cs && hit;
    assign data = cache;

    // Byte readers share a 16-bit word, 32-bit readers take two words
    generate
        if (BYTE_SLOT) begin : g_byte
            assign word_addr = BASE + 22'(pend_addr >> 1);
            assign fill_data = data_t'(pend_addr[0] ? rsp.data[15:8] : rsp.data[7:0]);
        end else begin : g_word
            assign word_addr = BASE + 22'({pend_addr, 1'b0});
            assign fill_data = data_t'(rsp.data);
        end
    endgenerate

    assign rd = '{req: pend && !downloading, addr: word_addr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            pend  <= 1'b0;
        end else if (downloading) begin
            // ROM content is changing
            valid <= 1'b0;
            pend  <= 1'b0;
        end else if (pend) begin
            if (rsp.done) begin
                valid <= 1'b1;
                pend  <= 1'b0;
            end
        end else if (miss) begin
            pend <= 1'b1;
        end
    end

    // Address is frozen while the read is in flight
    always_ff @(posedge clk) begin
        if (!pend && miss) begin
            pend_addr <= addr;
        end
        if (pend && rsp.done) begin
            tag   <= pend_addr;
            cache <= fill_data;
        end
    end

endmodule

// File: hdl/sbaskt_rom_arb.sv
// Fixed priority ROM arbiter
// Launches one slot read at a time and returns the burst to its owner

module sbaskt_rom_arb import sbaskt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  rd_req_t     main_rd,
    input  rd_req_t     snd_rd,
    input  rd_req_t     scr_rd,
    input  rd_req_t     obj_rd,
    input  logic        busy,
    output logic        start,
    output logic [21:0] start_addr,
    input  rd_rsp_t     rsp,
    output rd_rsp_t     main_rsp,
    output rd_rsp_t     snd_rsp,
    output rd_rsp_t     scr_rsp,
    output rd_rsp_t     obj_rsp
);

    logic [ 1:0] sel;
    logic        inflight;
    logic        any_req;
    logic [ 1:0] pick;
    logic [21:0] pick_addr;
    logic        launch;

    // Main CPU first, objects last
    always_comb begin
        any_req   = 1'b1;
        pick      = 2'd0;
        pick_addr = main_rd.addr;
        if (main_rd.req) begin
            pick      = 2'd0;
            pick_addr = main_rd.addr;
        end else if (snd_rd.req) begin
            pick      = 2'd1;
            pick_addr = snd_rd.addr;
        end else if (scr_rd.req) begin
            pick      = 2'd2;
            pick_addr = scr_rd.addr;
        end else if (obj_rd.req) begin
            pick      = 2'd3;
            pick_addr = obj_rd.addr;
        end else begin
            any_req = 1'b0;
        end
    end

    // Busy rises a cycle after start, inflight covers that gap
    assign launch = any_req && !busy && !inflight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start    <= 1'b0;
            inflight <= 1'b0;
            sel      <= 2'd0;
        end else begin
            start <= launch;
            if (launch) begin
                inflight <= 1'b1;
                sel      <= pick;
            end else if (rsp.done) begin
                inflight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            start_addr <= pick_addr;
        end
    end

    assign main_rsp = '{done: rsp.done && inflight && sel == 2'd0, data: rsp.data};
    assign snd_rsp  = '{done: rsp.done && inflight && sel == 2'd1, data: rsp.data};
    assign scr_rsp  = '{done: rsp.done && inflight && sel == 2'd2, data: rsp.data};
    assign obj_rsp  = '{done: rsp.done && inflight && sel == 2'd3, data: rsp.data};

endmodule

// File: hdl/sbaskt_sdram_port.sv
// SDRAM read port
// Holds the request until ack and assembles the two-word burst

module sbaskt_sdram_port import sbaskt_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic [21:0] start_addr,
    output logic        busy,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic [15:0] data_read,
    input  logic        data_dst,
    input  logic        data_rdy,
    output rd_rsp_t     rsp
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_COLLECT
    } state_t;

    state_t      state;
    logic [15:0] low_word;
    logic        rsp_done;
    logic [31:0] rsp_data;

    assign busy = state != ST_IDLE;
    assign rsp  = '{done: rsp_done, data: rsp_data};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            rsp_done  <= 1'b0;
        end else begin
            rsp_done <= 1'b0;
            case (state)
                ST_IDLE: if (start) begin
                    sdram_req <= 1'b1;
                    state     <= ST_REQ;
                end
                ST_REQ: if (sdram_ack) begin
                    sdram_req <= 1'b0;
                    state     <= ST_COLLECT;
                end
                ST_COLLECT: if (data_rdy) begin
                    rsp_done <= 1'b1;
                    state    <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // First word of the burst lands in the low half
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start) begin
            sdram_addr <= start_addr;
        end
        if (busy && data_dst) begin
            low_word <= data_read;
        end
        if (state == ST_COLLECT && data_rdy) begin
            rsp_data <= {data_read, low_word};
        end
    end

endmodule

// File: hdl/sbaskt_game.sv
// Super Basketball ROM subsystem
// Download decoding plus four cached ROM readers sharing one SDRAM port

`include "sbaskt_consts.svh"

module sbaskt_game import sbaskt_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    // Download
    input  logic                 downloading,
    output logic                 dwnld_busy,
    input  logic [24:0]          ioctl_addr,
    input  logic [ 7:0]          ioctl_dout,
    input  logic                 ioctl_wr,
    output prog_bus_t            prog,
    // SDRAM
    output logic                 sdram_req,
    output logic [21:0]          sdram_addr,
    input  logic [15:0]          data_read,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  logic                 sdram_ack,
    // ROM readers
    input  logic                 main_cs,
    input  logic [`MAIN_AW-1:0]  main_addr,
    output byte_data_t           main_data,
    output logic                 main_ok,
    input  logic                 snd_cs,
    input  logic [`SND_AW-1:0]   snd_addr,
    output byte_data_t           snd_data,
    output logic                 snd_ok,
    input  logic                 scr_cs,
    input  logic [`SCR_AW-1:0]   scr_addr,
    output word_data_t           scr_data,
    output logic                 scr_ok,
    input  logic                 obj_cs,
    input  logic [`OBJ_AW-1:0]   obj_addr,
    output word_data_t           obj_data,
    output logic                 obj_ok
);

    rd_req_t     main_rd;
    rd_req_t     snd_rd;
    rd_req_t     scr_rd;
    rd_req_t     obj_rd;
    rd_rsp_t     main_rsp;
    rd_rsp_t     snd_rsp;
    rd_rsp_t     scr_rsp;
    rd_rsp_t     obj_rsp;
    rd_rsp_t     port_rsp;
    logic        port_busy;
    logic        start;
    logic [21:0] start_addr;

    assign dwnld_busy = downloading;

    sbaskt_dwnld u_dwnld (
        .clk        (clk),
        .rst_n      (rst_n),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .ioctl_wr   (ioctl_wr),
        .prog       (prog)
    );

    sbaskt_rom_slot #(.data_t(byte_data_t), .AW(`MAIN_AW), .OFFSET(22'd0)) u_main_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .cs          (main_cs),
        .addr        (main_addr),
        .data        (main_data),
        .ok          (main_ok),
        .rd          (main_rd),
        .rsp         (main_rsp)
    );

    sbaskt_rom_slot #(.data_t(byte_data_t), .AW(`SND_AW), .OFFSET(`SND_START)) u_snd_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .cs          (snd_cs),
        .addr        (snd_addr),
        .data        (snd_data),
        .ok          (snd_ok),
        .rd          (snd_rd),
        .rsp         (snd_rsp)
    );

    sbaskt_rom_slot #(.data_t(word_data_t), .AW(`SCR_AW), .OFFSET(`SCR_START)) u_scr_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .cs          (scr_cs),
        .addr        (scr_addr),
        .data        (scr_data),
        .ok          (scr_ok),
        .rd          (scr_rd),
        .rsp         (scr_rsp)
    );

    sbaskt_rom_slot #(.data_t(word_data_t), .AW(`OBJ_AW), .OFFSET(`OBJ_START)) u_obj_slot (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .cs          (obj_cs),
        .addr        (obj_addr),
        .data        (obj_data),
        .ok          (obj_ok),
        .rd          (obj_rd),
        .rsp         (obj_rsp)
    );

    sbaskt_rom_arb u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .main_rd    (main_rd),
        .snd_rd     (snd_rd),
        .scr_rd     (scr_rd),
        .obj_rd     (obj_rd),
        .busy       (port_busy),
        .start      (start),
        .start_addr (start_addr),
        .rsp        (port_rsp),
        .main_rsp   (main_rsp),
        .snd_rsp    (snd_rsp),
        .scr_rsp    (scr_rsp),
        .obj_rsp    (obj_rsp)
    );

    sbaskt_sdram_port u_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .start_addr (start_addr),
        .busy       (port_busy),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_read  (data_read),
        .data_dst   (data_dst),
        .data_rdy   (data_rdy),
        .rsp        (port_rsp)
    );

endmodule

// File: testbench/sdram_model.sv
// SDRAM read model for the ROM testbench
// Random ack and data delays, each word holds its own address XOR a constant

module sdram_model (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic [21:0] addr,
    output logic        ack,
    output logic [15:0] dout,
    output logic        dst,
    output logic        rdy
);

    integer      seed;
    logic [21:0] burst_addr;

    function automatic logic [15:0] word_at(input logic [21:0] a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    // Zero to three idle cycles
    task automatic idle_gap();
        int n;
        n = $unsigned($random(seed)) % 4;
        repeat (n) @(negedge clk);
    endtask

    initial begin
        seed = 32'h4291_91a6;
        ack  = 1'b0;
        dst  = 1'b0;
        rdy  = 1'b0;
        dout = 16'h0000;
        forever begin
            @(negedge clk);
            if (rst_n && req) begin
                burst_addr = addr;
                idle_gap();
                ack = 1'b1;
                @(negedge clk);
                ack = 1'b0;
                idle_gap();
                // Two-word burst, first word marked by dst
                dst  = 1'b1;
                dout = word_at(burst_addr);
                @(negedge clk);
                dst  = 1'b0;
                rdy  = 1'b1;
                dout = word_at(burst_addr + 22'd1);
                @(negedge clk);
                rdy = 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_sbaskt_game.sv
// Testbench for the ROM subsystem
// Drives downloads and slot reads against an SDRAM model while assertions check the outputs

`include "sbaskt_consts.svh"

module tb_sbaskt_game import sbaskt_pkg::*; ();

    localparam int N_RAND    = 12;
    localparam int N_READS   = 11 + N_RAND;
    localparam int N_DL      = 8;
    localparam int WD_CYCLES = 16 + 200 * N_READS + 4 * N_DL;

    logic               clk;
    logic               rst_n;
    logic               downloading;
    logic               dwnld_busy;
    logic [24:0]        ioctl_addr;
    logic [ 7:0]        ioctl_dout;
    logic               ioctl_wr;
    prog_bus_t          prog;
    logic               sdram_req;
    logic [21:0]        sdram_addr;
    logic [15:0]        data_read;
    logic               data_dst;
    logic               data_rdy;
    logic               sdram_ack;
    logic               main_cs;
    logic [`MAIN_AW-1:0] main_addr;
    byte_data_t         main_data;
    logic               main_ok;
    logic               snd_cs;
    logic [`SND_AW-1:0] snd_addr;
    byte_data_t         snd_data;
    logic               snd_ok;
    logic               scr_cs;
    logic [`SCR_AW-1:0] scr_addr;
    word_data_t         scr_data;
    logic               scr_ok;
    logic               obj_cs;
    logic [`OBJ_AW-1:0] obj_addr;
    word_data_t         obj_data;
    logic               obj_ok;

    integer             seed;
    byte_data_t         main_exp;
    byte_data_t         snd_exp;
    word_data_t         scr_exp;
    word_data_t         obj_exp;
    logic               wr_q;
    prog_bus_t          exp_prog;
    logic               req_d;
    int                 req_count;
    logic [21:0]        issued[$];

    sbaskt_game u_dut (.*);

    sdram_model u_sdram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sdram_req),
        .addr  (sdram_addr),
        .ack   (sdram_ack),
        .dout  (data_read),
        .dst   (data_dst),
        .rdy   (data_rdy)
    );

    always #2 clk = ~clk;

    // Expected ROM content
    function automatic logic [15:0] rom_word(input logic [21:0] wa);
        return wa[15:0] ^ 16'h5a3c;
    endfunction

    function automatic logic [21:0] byte_wa(input logic [21:0] start, input logic [15:0] a);
        return start / 2 + a / 2;
    endfunction

    function automatic logic [21:0] long_wa(input logic [21:0] start, input logic [15:0] a);
        return start / 2 + a * 2;
    endfunction

    function automatic logic [7:0] pick_byte(input logic [21:0] wa, input logic hi);
        logic [15:0] w;
        w = rom_word(wa);
        return hi ? w[15:8] : w[7:0];
    endfunction

    function automatic logic [31:0] burst_data(input logic [21:0] wa);
        return {rom_word(wa + 22'd1), rom_word(wa)};
    endfunction

    assign main_exp = pick_byte(byte_wa(22'd0, main_addr), main_addr[0]);
    assign snd_exp  = pick_byte(byte_wa(`SND_START, 16'(snd_addr)), snd_addr[0]);
    assign scr_exp  = burst_data(long_wa(`SCR_START, 16'(scr_addr)));
    assign obj_exp  = burst_data(long_wa(`OBJ_START, 16'(obj_addr)));

    // Programming bus expected one cycle after each download byte
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_q <= 1'b0;
        end else begin
            wr_q <= ioctl_wr;
            if (ioctl_wr) begin
                exp_prog.addr    <= 22'(ioctl_addr >> 1);
                exp_prog.mask    <= ioctl_addr[0] ? 2'b01 : 2'b10;
                exp_prog.prom_we <= ioctl_addr >= `PROM_START;
                exp_prog.we      <= ioctl_addr < `PROM_START;
                if (ioctl_addr >= {3'd0, `SCR_START} && ioctl_addr < {3'd0, `PCM_START}) begin
                    exp_prog.data <= {ioctl_dout[3:0], ioctl_dout[7:4]};
                end else begin
                    exp_prog.data <= ioctl_dout;
                end
            end
        end
    end

    // Log every SDRAM request as it starts
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_d     <= 1'b0;
            req_count <= 0;
        end else begin
            req_d <= sdram_req;
            if (sdram_req && !req_d) begin
                req_count <= req_count + 1;
                issued.push_back(sdram_addr);
            end
        end
    end

    task automatic value_error(input string name, input logic [35:0] got,
                               input logic [35:0] exp);
        $display("error: %s = %h, expected %h", name, got, exp);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    a_prog_write: assert property (@(posedge clk) disable iff (!rst_n)
        wr_q |-> prog == exp_prog)
        else value_error("prog", $sampled(prog), $sampled(exp_prog));
    a_prog_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !wr_q |-> {prog.we, prog.prom_we} == 2'b00)
        else value_error("prog.we/prom_we", $sampled({prog.we, prog.prom_we}), 0);
    a_dwnld_busy: assert property (@(posedge clk) disable iff (!rst_n)
        dwnld_busy == downloading)
        else value_error("dwnld_busy", $sampled(dwnld_busy), $sampled(downloading));
    a_main_data: assert property (@(posedge clk) disable iff (!rst_n)
        main_ok |-> main_data == main_exp)
        else value_error("main_data", $sampled(main_data), $sampled(main_exp));
    a_snd_data: assert property (@(posedge clk) disable iff (!rst_n)
        snd_ok |-> snd_data == snd_exp)
        else value_error("snd_data", $sampled(snd_data), $sampled(snd_exp));
    a_scr_data: assert property (@(posedge clk) disable iff (!rst_n)
        scr_ok |-> scr_data == scr_exp)
        else value_error("scr_data", $sampled(scr_data), $sampled(scr_exp));
    a_obj_data: assert property (@(posedge clk) disable iff (!rst_n)
        obj_ok |-> obj_data == obj_exp)
        else value_error("obj_data", $sampled(obj_data), $sampled(obj_exp));
    a_dl_req: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |-> !sdram_req)
        else value_error("sdram_req", $sampled(sdram_req), 0);
    a_dl_ok: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |-> {main_ok, snd_ok, scr_ok, obj_ok} == 4'b0000)
        else value_error("ok", $sampled({main_ok, snd_ok, scr_ok, obj_ok}), 0);

    // Slot 0 main, 1 snd, 2 scr, 3 obj
    task automatic set_cs(input int s, input logic v, input logic [15:0] a);
        case (s)
            0: begin
                main_cs   = v;
                main_addr = a;
            end
            1: begin
                snd_cs   = v;
                snd_addr = a[`SND_AW-1:0];
            end
            2: begin
                scr_cs   = v;
                scr_addr = a[`SCR_AW-1:0];
            end
            default: begin
                obj_cs   = v;
                obj_addr = a[`OBJ_AW-1:0];
            end
        endcase
    endtask

    function automatic logic slot_ok(input int s);
        case (s)
            0:       return main_ok;
            1:       return snd_ok;
            2:       return scr_ok;
            default: return obj_ok;
        endcase
    endfunction

    task automatic read_slot(input int s, input logic [15:0] a);
        @(negedge clk);
        set_cs(s, 1'b1, a);
        do begin
            @(negedge clk);
        end while (!slot_ok(s));
        set_cs(s, 1'b0, a);
    endtask

    task automatic dl_write(input logic [24:0] a, input logic [7:0] d);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, a read never completed", WD_CYCLES);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        int          n;
        int          s;
        logic [15:0] a;
        logic [21:0] order[4];

        seed        = 32'h4291_91a6;
        clk         = 1'b0;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        for (int i = 0; i < 4; i++) begin
            set_cs(i, 1'b0, 16'h0000);
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Single reads then a hit and a neighbouring miss
        read_slot(0, 16'h1235);
        n = req_count;
        read_slot(0, 16'h1235);
        assert (req_count == n) else fail_run("Cache hit on main issued an SDRAM request");
        read_slot(0, 16'h1234);
        assert (req_count == n + 1) else fail_run("Main miss did not issue exactly one read");
        read_slot(1, 16'h0abc);
        read_slot(2, 16'h0123);
        read_slot(3, 16'h2345);

        // All four slots miss together
        order[0] = byte_wa(22'd0, 16'h8001);
        order[1] = byte_wa(`SND_START, 16'h1f00);
        order[2] = long_wa(`SCR_START, 16'h1555);
        order[3] = long_wa(`OBJ_START, 16'h3aaa);
        @(negedge clk);
        n = req_count;
        set_cs(0, 1'b1, 16'h8001);
        set_cs(1, 1'b1, 16'h1f00);
        set_cs(2, 1'b1, 16'h1555);
        set_cs(3, 1'b1, 16'h3aaa);
        do begin
            @(negedge clk);
        end while (!(main_ok && snd_ok && scr_ok && obj_ok));
        for (int i = 0; i < 4; i++) begin
            set_cs(i, 1'b0, 16'h0000);
        end
        assert (req_count == n + 4) else fail_run("Concurrent misses did not give four reads");
        for (int i = 0; i < 4; i++) begin
            assert (issued[n + i] == order[i])
                else value_error("sdram_addr", issued[n + i], order[i]);
        end

        // Download with main still selected on its cached address
        @(negedge clk);
        downloading = 1'b1;
        set_cs(0, 1'b1, 16'h8001);
        dl_write(25'h000_0004, 8'ha5);
        dl_write({3'd0, `SCR_START} + 25'd3, 8'h3c);
        dl_write({3'd0, `OBJ_START} + 25'h10, 8'h71);
        dl_write({3'd0, `PCM_START} - 25'd1, 8'h9e);
        dl_write({3'd0, `PCM_START}, 8'h9e);
        dl_write(`PROM_START - 25'd1, 8'h42);
        dl_write(`PROM_START, 8'h0f);
        dl_write(`PROM_START + 25'h21, 8'hc3);
        @(negedge clk);
        set_cs(0, 1'b0, 16'h8001);
        downloading = 1'b0;
        n = req_count;
        read_slot(0, 16'h8001);
        assert (req_count == n + 1) else fail_run("Cache entry survived the download");

        repeat (N_RAND) begin
            s = $unsigned($random(seed)) % 4;
            a = 16'($random(seed));
            read_slot(s, a);
        end

        repeat (4) @(negedge clk);
        $display("Test passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+hdl
hdl/sbaskt_pkg.sv
hdl/sbaskt_dwnld.sv
hdl/sbaskt_rom_slot.sv
hdl/sbaskt_rom_arb.sv
hdl/sbaskt_sdram_port.sv
hdl/sbaskt_game.sv
testbench/sdram_model.sv
testbench/tb_sbaskt_game.sv
